/* bench/raybox_assert.sv */
// ##########################################################
// Sync and blanking assertions, bound into raybox
// Checked only while reset is low
// ##########################################################
`timescale 1ns/100ps

module raybox_assert import raybox_pkg::*; (
    input logic   clk,
    input logic   reset,
    input logic   hsync,
    input coord_t px,
    input logic   tick,
    input logic   visible,
    input color_t red,
    input color_t green,
    input color_t blue
);

    localparam coord_t HS_FIRST = 10'd656;
    localparam coord_t HS_LAST  = 10'd751;

    assert property (@(posedge clk) disable iff (reset)
        !hsync |-> (px >= HS_FIRST && px <= HS_LAST))
        else $error("hsync low outside its window");

    assert property (@(posedge clk) disable iff (reset) tick |=> !tick)  // Single cycle frame tick
        else $error("frame tick longer than one cycle");

    assert property (@(posedge clk) disable iff (reset)
        !visible |-> (red == '0 && green == '0 && blue == '0))
        else $error("colour driven during blanking");

endmodule

bind raybox raybox_assert u_raybox_assert (
    .clk     (clk),
    .reset   (reset),
    .hsync   (hsync),
    .px      (px),
    .tick    (u_scan.tick),
    .visible (u_scan.visible),
    .red     (red),
    .green   (green),
    .blue    (blue)
);

/* bench/raybox_tb.sv */
// ##########################################################
// Testbench for the raybox display path
// Runs four whole frames from reset: map off, map on,
// host loads in and out of vblank, then random buttons
// Expected colours come from a model of the map rules
// ##########################################################
`timescale 1ns/100ps

module raybox_tb import raybox_pkg::*; ();

    localparam int H_TOTAL        = 800;
    localparam int V_TOTAL        = 525;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;     // 420000
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 20000;  // Four frames plus slack
    localparam fixed_t X_START    = 24'sd6144;             // 1.5
    localparam fixed_t Y_START    = 24'sd55296;            // 13.5
    localparam fixed_t MOVE_STEP  = 24'sd80;

    logic   clk = 1'b0;
    logic   reset;
    logic   show_map;
    logic   move_l;
    logic   move_r;
    logic   move_f;
    logic   move_b;
    logic   write_new_position;
    fixed_t new_player_x;
    fixed_t new_player_y;
    color_t red;
    color_t green;
    color_t blue;
    logic   hsync;
    logic   vsync;
    coord_t px;
    coord_t py;
    frame_t frame_num;

    coord_t exp_h;          // Model beam position
    coord_t exp_v;
    frame_t exp_frame;
    fixed_t model_x;        // Model player position
    fixed_t model_y;
    int     seed;
    int     error_count = 0;
    int     cycle_count = 0;

    raybox u_raybox (.*);

    always #5 clk = ~clk;   // 10 ns period

    task automatic stop_run(input string why);
        error_count++;
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_coord(input string name, input coord_t got, input coord_t exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_color(input string name, input color_t got, input color_t exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h at h=0x%h v=0x%h",
                               name, got, exp, exp_h, exp_v));
    endtask

    task automatic check_frame(input string name, input frame_t got, input frame_t exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_sync(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h at h=0x%h v=0x%h",
                               name, got, exp, exp_h, exp_v));
    endtask

    // Expected {r, g, b} for one pixel
    function automatic logic [5:0] ref_color(input coord_t h, input coord_t v,
                                             input logic map_on,
                                             input fixed_t x, input fixed_t y);
        int hh;
        int vv;
        int col;
        int row;
        logic ovl;
        logic on_cell;
        logic on_pixel;
        logic [1:0] mv;
        hh = int'(h);
        vv = int'(v);
        col = (hh / 16) % 16;                          // 16 pixel cells, 16 wide map
        row = (vv / 16) % 16;
        ovl = map_on && (hh < 257) && (vv < 257);
        on_cell = ovl && (((int'($unsigned(x)) >> 12) % 16) == col)
                      && (((int'($unsigned(y)) >> 12) % 16) == row);
        on_pixel = on_cell && (((int'($unsigned(x)) >> 8) % 16) == hh % 16)
                           && (((int'($unsigned(y)) >> 8) % 16) == vv % 16);
        if (col == 0 || col == 15 || row == 0 || row == 15)
            mv = 2'd3;                                 // Outer wall
        else if (col % 4 == 0 && row % 4 == 0)
            mv = 2'd1;                                 // Pillar
        else
            mv = 2'd0;
        if (hh >= 640 || vv >= 480) return 6'd0;       // Blanking
        if (on_pixel) return {2'd3, 2'd3, 2'd0};
        if (on_cell) return {2'd0, 2'd1, 2'd0};
        if (ovl && (hh % 16 == 0 || vv % 16 == 0)) return {2'd0, 2'd0, 2'd1};
        if (ovl) return {4'd0, mv};
        if (hh < 66 || hh >= 574) return {2'd1, 2'd0, 2'd1};
        if (vv < 240) return {2'd1, 2'd1, 2'd1};
        return {2'd2, 2'd2, 2'd2};
    endfunction

    // Model of counters and player state, steps on the same edges as the DUT
    always @(posedge clk) begin
        if (reset) begin
            exp_h     <= '0;
            exp_v     <= '0;
            exp_frame <= '0;
            model_x   <= X_START;
            model_y   <= Y_START;
        end else begin
            if (exp_h == coord_t'(H_TOTAL - 1)) begin
                exp_h <= '0;
                if (exp_v == coord_t'(V_TOTAL - 1)) begin
                    exp_v     <= '0;
                    exp_frame <= exp_frame + 1'b1;
                end else begin
                    exp_v <= exp_v + 1'b1;
                end
            end else begin
                exp_h <= exp_h + 1'b1;
            end
            if (write_new_position && exp_v < 10'd480) begin
                model_x <= new_player_x;               // Load only on visible lines
                model_y <= new_player_y;
            end else if (exp_h == '0 && exp_v == '0) begin
                if (move_l) model_x <= model_x - MOVE_STEP;
                else if (move_r) model_x <= model_x + MOVE_STEP;
                if (move_f) model_y <= model_y - MOVE_STEP;
                else if (move_b) model_y <= model_y + MOVE_STEP;
            end
        end
    end

    // Compare on the falling edge, where every output has settled
    always @(negedge clk) begin : compare
        logic [5:0] exp_rgb;
        if (!reset) begin
            exp_rgb = ref_color(exp_h, exp_v, show_map, model_x, model_y);
            check_coord("px", px, exp_h);
            check_coord("py", py, exp_v);
            check_frame("frame_num", frame_num, exp_frame);
            check_sync("hsync", hsync, !(exp_h >= 10'd656 && exp_h <= 10'd751));
            check_sync("vsync", vsync, !(exp_v >= 10'd490 && exp_v <= 10'd491));
            check_color("red", red, exp_rgb[5:4]);
            check_color("green", green, exp_rgb[3:2]);
            check_color("blue", blue, exp_rgb[1:0]);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            stop_run($sformatf("timeout, run did not finish in %0d cycles", TIMEOUT_CYCLES));
    end

    // One frame of random buttons, new values at each line start
    task automatic button_frame(input bit with_loads);
        logic [31:0] rnd;
        logic [31:0] pos;
        for (int line = 0; line < V_TOTAL; line++) begin
            rnd = $random(seed);
            move_l <= rnd[0];
            move_r <= rnd[1];
            move_f <= rnd[2];
            move_b <= rnd[3];
            if (with_loads && (line == 100 || line == 300)) begin
                pos = $random(seed);
                new_player_x <= {8'd0, pos[15:0]};
                new_player_y <= {8'd0, pos[31:16]};
                write_new_position <= 1'b1;            // One cycle pulse on a visible line
                @(posedge clk);
                write_new_position <= 1'b0;
                repeat (H_TOTAL - 1) @(posedge clk);
            end else begin
                if (with_loads && line == 490) begin
                    pos = $random(seed);
                    new_player_x <= {8'd0, pos[15:0]};
                    new_player_y <= {8'd0, pos[31:16]};
                    write_new_position <= 1'b1;        // Held through vblank only
                end
                if (with_loads && line == 521)
                    write_new_position <= 1'b0;
                repeat (H_TOTAL) @(posedge clk);
            end
        end
    endtask

    initial begin
        seed               = 32'hf77b6cac;
        reset              = 1'b1;
        show_map           = 1'b0;
        move_l             = 1'b0;
        move_r             = 1'b0;
        move_f             = 1'b0;
        move_b             = 1'b0;
        write_new_position = 1'b0;
        new_player_x       = '0;
        new_player_y       = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        repeat (FRAME_CYCLES) @(posedge clk);          // Map off, plain scene
        show_map <= 1'b1;
        repeat (FRAME_CYCLES) @(posedge clk);          // Map overlay, player at start
        button_frame(1'b1);
        button_frame(1'b0);                            // Vblank load must not show here
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+hdl
hdl/raybox_pkg.sv
hdl/raybox_if.sv
hdl/vga_sync.sv
hdl/player_state.sv
hdl/map_overlay.sv
hdl/pixel_mux.sv
hdl/raybox.sv
bench/raybox_assert.sv
bench/raybox_tb.sv

/* hdl/map_overlay.sv */
// ##########################################################
// Map overlay flags for the top left corner of the screen
// The map is fixed logic, 16x16 cells, no ROM
// Player cell uses only the low 4 integer bits of the
// position, so positions outside the map alias into it
// ##########################################################
`timescale 1ns/100ps
`include "raybox_settings.svh"

module map_overlay import raybox_pkg::*; (
    scan_if.sink      scan,
    input  logic      show_map,
    input  fixed_t    player_x,
    input  fixed_t    player_y,
    overlay_if.source overlay
);

    localparam int     MS        = `MAP_SCALE;
    localparam int     QF        = `Q_FRAC;
    localparam coord_t OVL_LIMIT = coord_t'(`MAP_OVERLAY_SIZE);

    logic [3:0] map_col;     // Cell under the beam
    logic [3:0] map_row;
    logic [3:0] sub_x;       // Pixel within the cell
    logic [3:0] sub_y;
    logic       in_overlay;
    logic       in_player_cell;

    // Outer wall all round, pillars on a 4 cell pitch
    function automatic map_val_t map_cell(input logic [3:0] col, input logic [3:0] row);
        logic edge_cell;
        logic pillar;
        edge_cell = (col == 4'd0) || (col == 4'd15) || (row == 4'd0) || (row == 4'd15);
        pillar    = (col[1:0] == 2'b00) && (row[1:0] == 2'b00);
        if (edge_cell) begin
            map_cell = 2'd3;
        end else if (pillar) begin
            map_cell = 2'd1;
        end else begin
            map_cell = 2'd0;   // Open floor
        end
    endfunction

    assign map_col = scan.h[MS+3:MS];
    assign map_row = scan.v[MS+3:MS];
    assign sub_x   = scan.h[MS-1:0];
    assign sub_y   = scan.v[MS-1:0];

    assign in_overlay = show_map && (scan.h < OVL_LIMIT) && (scan.v < OVL_LIMIT);

    // Player cell from the integer bits, player pixel from the top fraction bits
    assign in_player_cell = in_overlay
                         && (player_x[QF+3:QF] == map_col)
                         && (player_y[QF+3:QF] == map_row);

    assign overlay.in_overlay      = in_overlay;
    assign overlay.in_grid         = in_overlay && ((sub_x == '0) || (sub_y == '0));
    assign overlay.in_player_cell  = in_player_cell;
    assign overlay.in_player_pixel = in_player_cell
                                  && (player_x[QF-1:QF-MS] == sub_x)
                                  && (player_y[QF-1:QF-MS] == sub_y);
    assign overlay.map_val         = map_cell(map_col, map_row);

endmodule

/* hdl/pixel_mux.sv */
// ##########################################################
// Final pixel colour, 2 bits per channel
// Layers are resolved by fixed priority, overlay on top
// Output is forced to black outside the visible area
// ##########################################################
`timescale 1ns/100ps
`include "raybox_settings.svh"

module pixel_mux import raybox_pkg::*; (
    scan_if.sink    scan,
    overlay_if.sink overlay,
    output color_t  red,
    output color_t  green,
    output color_t  blue
);

    localparam coord_t BORDER_L = coord_t'(`BORDER_LEFT);
    localparam coord_t BORDER_R = coord_t'(`BORDER_RIGHT);
    localparam coord_t HORIZON  = coord_t'(`HALF_HEIGHT);

    layer_t layer;
    color_t r;        // Ungated channels
    color_t g;
    color_t b;
    logic   in_border;

    assign in_border = (scan.h < BORDER_L) || (scan.h >= BORDER_R);

    // Pick the topmost layer covering this pixel
    always_comb begin
        if (overlay.in_player_pixel)     layer = LAYER_PLAYER_PIXEL;
        else if (overlay.in_player_cell) layer = LAYER_PLAYER_CELL;
        else if (overlay.in_grid)        layer = LAYER_GRID;
        else if (overlay.in_overlay)     layer = LAYER_MAP;
        else if (in_border)              layer = LAYER_BORDER;
        else if (scan.v < HORIZON)       layer = LAYER_CEILING;
        else                             layer = LAYER_FLOOR;
    end

    always_comb begin
        case (layer)
            LAYER_PLAYER_PIXEL: {r, g, b} = {2'd3, 2'd3, 2'd0};           // Yellow
            LAYER_PLAYER_CELL:  {r, g, b} = {2'd0, 2'd1, 2'd0};           // Dark green
            LAYER_GRID:         {r, g, b} = {2'd0, 2'd0, 2'd1};           // Dark blue
            LAYER_MAP:          {r, g, b} = {2'd0, 2'd0, overlay.map_val};
            LAYER_BORDER:       {r, g, b} = {2'd1, 2'd0, 2'd1};           // Dark purple
            LAYER_CEILING:      {r, g, b} = {2'd1, 2'd1, 2'd1};           // Dark grey
            default:            {r, g, b} = {2'd2, 2'd2, 2'd2};           // Floor, light grey
        endcase
    end

    // Blanking, monitors expect black during sync and porches
    assign red   = scan.visible ? r : '0;
    assign green = scan.visible ? g : '0;
    assign blue  = scan.visible ? b : '0;

endmodule

/* hdl/player_state.sv */
// ##########################################################
// Player position registers
// Host load is taken only on visible lines, with no
// synchronizer, so inputs must be in the clk domain
// Motion is axis aligned, no facing direction
// ##########################################################
`timescale 1ns/100ps
`include "raybox_settings.svh"

module player_state import raybox_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    scan_if.sink   scan,
    input  logic   move_l,
    input  logic   move_r,
    input  logic   move_f,
    input  logic   move_b,
    input  logic   write_new_position,
    input  fixed_t new_player_x,
    input  fixed_t new_player_y,
    output fixed_t player_x,
    output fixed_t player_y
);

    localparam fixed_t X_START   = fixed_t'(`PLAYER_X_START);
    localparam fixed_t Y_START   = fixed_t'(`PLAYER_Y_START);
    localparam fixed_t MOVE_STEP = fixed_t'(`PLAYER_MOVE);
    localparam coord_t V_VIS_END = coord_t'(`V_VISIBLE);

    logic load_ok;   // Host write lands in the visible part of the frame

    assign load_ok = write_new_position && (scan.v < V_VIS_END);

    always_ff @(posedge clk) begin
        if (reset) begin
            player_x <= X_START;   // Centre of cell (1,13)
            player_y <= Y_START;
        end else if (load_ok) begin
            // Direct overwrite from host wins over motion
            player_x <= new_player_x;
            player_y <= new_player_y;
        end else if (scan.tick) begin
            // Once per frame, left beats right
            if (move_l) begin
                player_x <= player_x - MOVE_STEP;
            end else if (move_r) begin
                player_x <= player_x + MOVE_STEP;
            end

            // Forward is up the map, so towards smaller y
            if (move_f) begin
                player_y <= player_y - MOVE_STEP;
            end else if (move_b) begin
                player_y <= player_y + MOVE_STEP;
            end
        end
    end

endmodule

/* hdl/raybox.sv */
// ##########################################################
// Raybox display path top level
// Single clock domain, synchronous active high reset
// new_player_* and the buttons are sampled without
// synchronizers, drive them from the clk domain
// ##########################################################
`timescale 1ns/100ps

module raybox import raybox_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   show_map,            // Map overlay on
    input  logic   move_l,
    input  logic   move_r,
    input  logic   move_f,
    input  logic   move_b,
    input  logic   write_new_position,  // Host position load
    input  fixed_t new_player_x,
    input  fixed_t new_player_y,
    output color_t red,
    output color_t green,
    output color_t blue,
    output logic   hsync,
    output logic   vsync,
    output coord_t px,                  // Current beam x
    output coord_t py,                  // Current beam y
    output frame_t frame_num
);

    scan_if    u_scan ();
    overlay_if u_overlay ();

    fixed_t player_x;
    fixed_t player_y;

    vga_sync u_vga_sync (
        .clk       (clk),
        .reset     (reset),
        .scan      (u_scan.source),
        .hsync     (hsync),
        .vsync     (vsync),
        .frame_num (frame_num)
    );

    player_state u_player_state (
        .clk                (clk),
        .reset              (reset),
        .scan               (u_scan.sink),
        .move_l             (move_l),
        .move_r             (move_r),
        .move_f             (move_f),
        .move_b             (move_b),
        .write_new_position (write_new_position),
        .new_player_x       (new_player_x),
        .new_player_y       (new_player_y),
        .player_x           (player_x),
        .player_y           (player_y)
    );

    map_overlay u_map_overlay (
        .scan     (u_scan.sink),
        .show_map (show_map),
        .player_x (player_x),
        .player_y (player_y),
        .overlay  (u_overlay.source)
    );

    pixel_mux u_pixel_mux (
        .scan    (u_scan.sink),
        .overlay (u_overlay.sink),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    assign px = u_scan.h;
    assign py = u_scan.v;

endmodule

/* hdl/raybox_if.sv */
// ##########################################################
// Scan position and map overlay bundles
// scan_if has a single source, the VGA timing generator
// All signals are plain levels, no handshake
// ##########################################################
`timescale 1ns/100ps

// Beam position, shared by every stage of the pixel path
interface scan_if import raybox_pkg::*; ();

    coord_t h;        // Pixel within line
    coord_t v;        // Line within frame
    logic   visible;  // Inside the 640x480 area
    logic   tick;     // One cycle at the start of each frame

    modport source (
        output h,
        output v,
        output visible,
        output tick
    );

    modport sink (
        input h,
        input v,
        input visible,
        input tick
    );

endinterface

// Flags for the current pixel over the map overlay
interface overlay_if import raybox_pkg::*; ();

    logic     in_overlay;
    logic     in_grid;
    logic     in_player_cell;
    logic     in_player_pixel;
    map_val_t map_val;         // Only meaningful inside the overlay

    modport source (
        output in_overlay,
        output in_grid,
        output in_player_cell,
        output in_player_pixel,
        output map_val
    );

    modport sink (
        input in_overlay,
        input in_grid,
        input in_player_cell,
        input in_player_pixel,
        input map_val
    );

endinterface

/* hdl/raybox_pkg.sv */
// ##########################################################
// Shared types of the display path
// fixed_t is signed, integer part wraps at 2^11
// ##########################################################
`include "raybox_settings.svh"

package raybox_pkg;

    // Player position, Q12.12
    typedef logic signed [`Q_INT+`Q_FRAC-1:0] fixed_t;

    typedef logic [9:0]  coord_t;    // Screen x or y, up to 799
    typedef logic [10:0] frame_t;    // Free-running frame count
    typedef logic [1:0]  color_t;    // One channel, 2 bits per colour
    typedef logic [1:0]  map_val_t;  // Map cell contents

    // Winning layer of one pixel, listed from top to bottom
    typedef enum logic [2:0] {
        LAYER_PLAYER_PIXEL,
        LAYER_PLAYER_CELL,
        LAYER_GRID,
        LAYER_MAP,
        LAYER_BORDER,
        LAYER_CEILING,
        LAYER_FLOOR
    } layer_t;

endpackage

/* hdl/raybox_settings.svh */
// ##########################################################
// Display timing, geometry and motion constants
// Timing assumes a 25 MHz pixel clock for 640x480 at 60 Hz
// Map overlay assumes a 16x16 cell map
// ##########################################################
`ifndef RAYBOX_SETTINGS_SVH
`define RAYBOX_SETTINGS_SVH

// Horizontal timing in pixel clocks, 800 per line
`define H_VISIBLE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

// Vertical timing in lines, 525 per frame
`define V_VISIBLE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

`define HALF_HEIGHT 240        // Ceiling above, floor below
`define BORDER_LEFT 66         // Side border, left edge
`define BORDER_RIGHT 574       // Side border starts here on the right
`define MAP_SCALE 4            // Log2 of cell size in pixels
`define MAP_OVERLAY_SIZE 257   // 16 cells of 16 pixels plus the closing grid line

// Fixed-point position format
`define Q_INT 12
`define Q_FRAC 12

`define PLAYER_MOVE 80         // Walking step per frame, ten times 2^-9
`define PLAYER_X_START 6144    // 1.5
`define PLAYER_Y_START 55296   // 13.5

`endif

/* hdl/vga_sync.sv */
// ##########################################################
// VGA 640x480 timing generator
// Sync pulses are active low and decoded straight from
// the counters, so they are not glitch free on a pad
// ##########################################################
`timescale 1ns/100ps
`include "raybox_settings.svh"

module vga_sync import raybox_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    scan_if.source scan,
    output logic   hsync,
    output logic   vsync,
    output frame_t frame_num
);

    localparam int H_TOTAL = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;  // 800
    localparam int V_TOTAL = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;  // 525

    localparam coord_t H_LAST       = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST       = coord_t'(V_TOTAL - 1);
    localparam coord_t H_VIS_END    = coord_t'(`H_VISIBLE);
    localparam coord_t V_VIS_END    = coord_t'(`V_VISIBLE);
    localparam coord_t H_SYNC_FIRST = coord_t'(`H_VISIBLE + `H_FRONT);             // 656
    localparam coord_t H_SYNC_LAST  = coord_t'(`H_VISIBLE + `H_FRONT + `H_SYNC - 1);
    localparam coord_t V_SYNC_FIRST = coord_t'(`V_VISIBLE + `V_FRONT);             // 490
    localparam coord_t V_SYNC_LAST  = coord_t'(`V_VISIBLE + `V_FRONT + `V_SYNC - 1);

    coord_t h;
    coord_t v;
    logic   h_wrap;   // Last pixel of a line
    logic   v_wrap;   // Last line of a frame

    assign h_wrap = (h == H_LAST);
    assign v_wrap = (v == V_LAST);

    // Pixel and line counters
    always_ff @(posedge clk) begin
        if (reset) begin
            h <= '0;
            v <= '0;
        end else if (h_wrap) begin
            h <= '0;
            v <= v_wrap ? '0 : v + 1'b1;  // Next line, or back to top
        end else begin
            h <= h + 1'b1;
        end
    end

    // Frame count steps as the beam returns to the top left
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_num <= '0;
        end else if (h_wrap && v_wrap) begin
            frame_num <= frame_num + 1'b1;
        end
    end

    assign scan.h       = h;
    assign scan.v       = v;
    assign scan.visible = (h < H_VIS_END) && (v < V_VIS_END);
    assign scan.tick    = (h == '0) && (v == '0);  // Also high right after reset

    assign hsync = !((h >= H_SYNC_FIRST) && (h <= H_SYNC_LAST));  // Low 656..751
    assign vsync = !((v >= V_SYNC_FIRST) && (v <= V_SYNC_LAST));  // Low 490..491

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the raybox testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module raybox_tb -f flist.f -o raybox_sim \
    || { echo "build failed"; exit 1; }

output=$(./obj_dir/raybox_sim 2>&1)
echo "$output"

echo "$output" | grep -qx "all tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }
